//--- bench/kbd_device_tb.sv
// Host keeps irq_busy low; PS/2 half period is 20 to 40 clocks, so one frame takes at most 881 clocks
`timescale 1ns/1ns
`default_nettype none
`include "kbd_consts.svh"

module kbd_device_tb
	import kbd_pkg::*;
();

	localparam int MAX_ENTRIES = 80;
	localparam int WAIT_LIMIT = 100;
	// Table actions
	localparam int K_FRAME = 0;
	localparam int K_BAD_PAR = 1;
	localparam int K_BAD_STOP = 2;
	localparam int K_READ = 3;
	localparam int K_POST = 4;
	localparam int K_WRITE = 5;
	localparam int K_RSP_BUSY = 6;
	localparam int K_BUSY_CHK = 7;
	localparam int K_IRQ = 8;
	localparam int K_NO_IRQ = 9;

	logic clock;
	logic rst_n;
	logic dev_req;
	logic dev_rw;
	gci_addr_t dev_addr;
	gci_data_t dev_data_in;
	logic dev_busy;
	logic rsp_req;
	gci_data_t rsp_data;
	logic rsp_busy;
	logic irq_req;
	irq_data_t irq_data;
	logic irq_busy;
	logic irq_ack;
	logic ps2_clock;
	logic ps2_data;

	// Stimulus table with expected values from the model
	int ent_kind [MAX_ENTRIES];
	gci_addr_t ent_addr [MAX_ENTRIES];
	gci_data_t ent_data [MAX_ENTRIES];
	gci_data_t ent_exp [MAX_ENTRIES];
	int n_entries = 0;

	// Reference model of the scan queue and flags
	scan_code_t model_q [$];
	logic model_ovf = 1'b0;
	logic model_ferr = 1'b0;
	logic model_ien = 1'b0;

	// Replies still owed by the DUT in request order
	gci_data_t pending_exp [$];
	int pass_count = 0;
	int fail_count = 0;
	logic entry_ok;
	int cycle_count = 0;
	int cycle_limit = 1000000;
	int seed_val;

	kbd_device kbd_device_i (
		.clock(clock),
		.rst_n(rst_n),
		.dev_req(dev_req),
		.dev_rw(dev_rw),
		.dev_addr(dev_addr),
		.dev_data_in(dev_data_in),
		.dev_busy(dev_busy),
		.rsp_req(rsp_req),
		.rsp_data(rsp_data),
		.rsp_busy(rsp_busy),
		.irq_req(irq_req),
		.irq_data(irq_data),
		.irq_busy(irq_busy),
		.irq_ack(irq_ack),
		.ps2_clock(ps2_clock),
		.ps2_data(ps2_data)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	// Run limit
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Run stopped: cycle limit of %0d reached at %0t ns", cycle_limit, $time);
			$display("Test failed");
			$finish;
		end
	end

	function automatic string kind_name(input int k);
		case (k)
			K_FRAME: return "good frame";
			K_BAD_PAR: return "bad parity frame";
			K_BAD_STOP: return "bad stop frame";
			K_READ: return "read";
			K_POST: return "posted read";
			K_WRITE: return "write";
			K_RSP_BUSY: return "set rsp_busy";
			K_BUSY_CHK: return "dev_busy check";
			K_IRQ: return "interrupt";
			default: return "no interrupt";
		endcase
	endfunction

	task automatic add_entry(input int kind, input gci_addr_t addr, input gci_data_t data,
			input gci_data_t exp);
		ent_kind[n_entries] = kind;
		ent_addr[n_entries] = addr;
		ent_data[n_entries] = data;
		ent_exp[n_entries] = exp;
		n_entries++;
	endtask

	// Status word from the register map
	function automatic gci_data_t model_status();
		gci_data_t w;
		w = '0;
		w[0] = (model_q.size() != 0);
		w[1] = model_ovf;
		w[2] = model_ferr;
		w[3] = model_ien;
		w[11:8] = 4'(model_q.size());
		return w;
	endfunction

	task automatic plan_frame(input int kind);
		scan_code_t c;
		c = 8'($urandom % 256);
		if (kind != K_FRAME) begin
			model_ferr = 1'b1;
		end else if (model_q.size() < `KBD_SCAN_DEPTH) begin
			model_q.push_back(c);
		end else begin
			model_ovf = 1'b1;
		end
		add_entry(kind, '0, gci_data_t'(c), '0);
	endtask

	task automatic plan_read(input gci_addr_t addr, input int kind);
		gci_data_t exp;
		exp = '0;
		if (addr == `KBD_ADDR_STATUS) begin
			exp = model_status();
		end else if (addr == `KBD_ADDR_DATA && model_q.size() != 0) begin
			exp = gci_data_t'(model_q.pop_front());
		end
		add_entry(kind, addr, '0, exp);
	endtask

	task automatic plan_write(input gci_addr_t addr, input gci_data_t data);
		if (addr == `KBD_ADDR_CONTROL) begin
			model_ien = data[0];
			if (data[1]) begin
				model_ovf = 1'b0;
				model_ferr = 1'b0;
			end
		end
		add_entry(K_WRITE, addr, data, '0);
	endtask

	task automatic check_data(input gci_data_t got, input gci_data_t exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
			entry_ok = 1'b0;
		end
	endtask

	task automatic check_irq(input irq_data_t got, input irq_data_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: irq_data is 0x%06h, expected 0x%06h", $time, got, exp);
			entry_ok = 1'b0;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			entry_ok = 1'b0;
		end
	endtask

	// Keyboard drives data only while the PS/2 clock is high
	task automatic send_frame(input scan_code_t code, input int kind);
		logic [10:0] bits;
		int half;
		half = 20 + int'($urandom % 21);
		bits = {1'b1, ~^code, code, 1'b0};
		if (kind == K_BAD_PAR) begin
			bits[9] = ^code;
		end
		if (kind == K_BAD_STOP) begin
			bits[10] = 1'b0;
		end
		@(posedge clock);
		for (int i = 0; i < 11; i++) begin
			ps2_data <= bits[i];
			repeat (half) @(posedge clock);
			ps2_clock <= 1'b0;
			repeat (half) @(posedge clock);
			ps2_clock <= 1'b1;
		end
		ps2_data <= 1'b1;
	endtask

	// Holds dev_req until an edge with dev_busy low takes it
	task automatic issue_request(input logic rw, input gci_addr_t addr, input gci_data_t data,
			output logic accepted);
		int waited;
		waited = 0;
		accepted = 1'b0;
		@(posedge clock);
		dev_req <= 1'b1;
		dev_rw <= rw;
		dev_addr <= addr;
		dev_data_in <= data;
		while (!accepted && waited < WAIT_LIMIT) begin
			@(negedge clock);
			if (!dev_busy) begin
				accepted = 1'b1;
			end else begin
				waited++;
			end
		end
		@(posedge clock);
		dev_req <= 1'b0;
		if (!accepted) begin
			$display("Request to 0x%08h was never accepted, dev_busy stayed high", addr);
			entry_ok = 1'b0;
		end
	endtask

	task automatic collect_reply();
		gci_data_t exp;
		int waited;
		logic seen;
		exp = pending_exp.pop_front();
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < WAIT_LIMIT) begin
			@(negedge clock);
			if (rsp_req) begin
				seen = 1'b1;
			end else begin
				waited++;
			end
		end
		if (seen) begin
			check_data(rsp_data, exp, "read reply");
		end else begin
			$display("No read reply arrived within %0d cycles", WAIT_LIMIT);
			entry_ok = 1'b0;
		end
	endtask

	task automatic check_irq_entry(input irq_data_t exp);
		int waited;
		logic seen;
		logic dropped;
		waited = 0;
		seen = 1'b0;
		dropped = 1'b0;
		while (!seen && waited < WAIT_LIMIT) begin
			@(negedge clock);
			if (irq_req) begin
				seen = 1'b1;
			end else begin
				waited++;
			end
		end
		if (!seen) begin
			$display("No interrupt request was raised after the scan code arrived");
			entry_ok = 1'b0;
		end else begin
			check_irq(irq_data, exp);
			// Level must hold with no ack
			repeat (8) begin
				@(negedge clock);
				dropped = dropped | ~irq_req;
			end
			if (dropped) begin
				$display("Interrupt request dropped before it was acknowledged");
				entry_ok = 1'b0;
			end
			@(posedge clock);
			irq_ack <= 1'b1;
			@(posedge clock);
			irq_ack <= 1'b0;
			@(negedge clock);
			check_flag(irq_req, 1'b0, "irq_req after acknowledge");
		end
	endtask

	task automatic check_no_irq();
		logic raised;
		raised = 1'b0;
		repeat (16) begin
			@(negedge clock);
			raised = raised | irq_req;
		end
		if (raised) begin
			$display("Interrupt request was raised while interrupts were disabled");
			entry_ok = 1'b0;
		end
	endtask

	initial begin
		logic ok;
		seed_val = $urandom(32'ha858cf9a);
		rst_n = 1'b0;
		dev_req = 1'b0;
		dev_rw = 1'b0;
		dev_addr = '0;
		dev_data_in = '0;
		rsp_busy = 1'b0;
		irq_busy = 1'b0;
		irq_ack = 1'b0;
		ps2_clock = 1'b1;
		ps2_data = 1'b1;

		// Good frames come back in order
		repeat (3) plan_frame(K_FRAME);
		plan_read(`KBD_ADDR_STATUS, K_READ);
		repeat (3) plan_read(`KBD_ADDR_DATA, K_READ);
		plan_read(`KBD_ADDR_STATUS, K_READ);
		// Framing errors and their clear
		plan_frame(K_BAD_PAR);
		plan_read(`KBD_ADDR_STATUS, K_READ);
		plan_frame(K_BAD_STOP);
		plan_read(`KBD_ADDR_STATUS, K_READ);
		plan_write(`KBD_ADDR_CONTROL, 32'h2);
		plan_read(`KBD_ADDR_STATUS, K_READ);
		// Overflow and then a read of the empty queue
		repeat (9) plan_frame(K_FRAME);
		plan_read(`KBD_ADDR_STATUS, K_READ);
		repeat (9) plan_read(`KBD_ADDR_DATA, K_READ);
		plan_write(`KBD_ADDR_CONTROL, 32'h2);
		plan_read(`KBD_ADDR_STATUS, K_READ);
		// Interrupt on and later off
		plan_write(`KBD_ADDR_CONTROL, 32'h1);
		plan_frame(K_FRAME);
		add_entry(K_IRQ, '0, '0, gci_data_t'(model_q.size()));
		plan_read(`KBD_ADDR_STATUS, K_READ);
		plan_read(`KBD_ADDR_DATA, K_READ);
		plan_write(`KBD_ADDR_CONTROL, 32'h0);
		plan_frame(K_FRAME);
		add_entry(K_NO_IRQ, '0, '0, '0);
		plan_read(`KBD_ADDR_DATA, K_READ);
		// Reads held back by rsp_busy fill the reply queue
		repeat (2) plan_frame(K_FRAME);
		add_entry(K_RSP_BUSY, '0, 32'h1, '0);
		plan_read(`KBD_ADDR_STATUS, K_POST);
		repeat (2) plan_read(`KBD_ADDR_DATA, K_POST);
		plan_read(32'h0000_000c, K_POST);
		add_entry(K_BUSY_CHK, '0, '0, 32'h1);
		add_entry(K_RSP_BUSY, '0, 32'h0, '0);
		add_entry(K_BUSY_CHK, '0, '0, 32'h0);
		// Unmapped offsets
		plan_frame(K_FRAME);
		plan_read(32'h0000_000c, K_READ);
		plan_read(32'h0000_0010, K_READ);
		plan_write(32'h0000_000c, 32'hffff_ffff);
		plan_write(`KBD_ADDR_DATA, 32'h3);
		plan_write(`KBD_ADDR_STATUS, 32'h3);
		plan_read(`KBD_ADDR_STATUS, K_READ);
		plan_read(`KBD_ADDR_DATA, K_READ);
		cycle_limit = n_entries * 11 * 2 * 40 + 500;

		repeat (16) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		entry_ok = 1'b1;
		check_flag(dev_busy, 1'b0, "dev_busy after reset");
		check_flag(rsp_req, 1'b0, "rsp_req after reset");
		check_flag(irq_req, 1'b0, "irq_req after reset");
		if (entry_ok) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		$display("reset outputs: %s", entry_ok ? "ok" : "mismatch");

		for (int i = 0; i < n_entries; i++) begin
			entry_ok = 1'b1;
			case (ent_kind[i])
				K_FRAME, K_BAD_PAR, K_BAD_STOP: begin
					send_frame(scan_code_t'(ent_data[i]), ent_kind[i]);
				end
				K_READ, K_POST: begin
					issue_request(1'b0, ent_addr[i], '0, ok);
					if (ok) begin
						pending_exp.push_back(ent_exp[i]);
					end
					while (ent_kind[i] == K_READ && pending_exp.size() > 0) begin
						collect_reply();
					end
				end
				K_WRITE: issue_request(1'b1, ent_addr[i], ent_data[i], ok);
				K_RSP_BUSY: begin
					@(posedge clock);
					rsp_busy <= ent_data[i][0];
					while (!ent_data[i][0] && pending_exp.size() > 0) begin
						collect_reply();
					end
				end
				K_BUSY_CHK: begin
					repeat (2) @(negedge clock);
					check_flag(dev_busy, ent_exp[i][0], "dev_busy");
				end
				K_IRQ: check_irq_entry(irq_data_t'(ent_exp[i]));
				default: check_no_irq();
			endcase
			if (entry_ok) begin
				pass_count++;
			end else begin
				fail_count++;
			end
			$display("entry %0d %s: %s", i, kind_name(ent_kind[i]), entry_ok ? "ok" : "mismatch");
		end

		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- common/kbd_consts.svh
// Register offsets are full bus addresses; queue depths are expected to be powers of two
`ifndef KBD_CONSTS_SVH
`define KBD_CONSTS_SVH

// Register map, word offsets
`define KBD_ADDR_STATUS  32'h0000_0000
`define KBD_ADDR_DATA    32'h0000_0004
`define KBD_ADDR_CONTROL 32'h0000_0008

// Scan code queue depth
// Status bits 11:8 hold its occupancy, so 15 entries at most
`define KBD_SCAN_DEPTH 8

// Read reply queue depth
// Also the number of reads the host may have in flight
`define KBD_REPLY_DEPTH 4

// Longest gap between PS/2 falling edges, in system clocks
// A partial frame older than this is dropped
`define KBD_PS2_TIMEOUT 2000

`endif

//--- common/kbd_pkg.sv
// Types only; widths follow the GCI device port of the core (32-bit bus, 24-bit irq data)
`default_nettype none

package kbd_pkg;

	// Device bus address as driven by the core
	typedef logic [31:0] gci_addr_t;

	// Device bus data word
	// Also the payload of the reply queue
	typedef logic [31:0] gci_data_t;

	// Data word carried next to the interrupt request
	typedef logic [23:0] irq_data_t;

	// One received PS/2 byte
	// Also the payload of the scan queue
	typedef logic [7:0] scan_code_t;

	// Register selected by a host access
	// reg_none covers every unmapped offset
	typedef enum logic [1:0] {
		reg_status  = 2'd0,
		reg_data    = 2'd1,
		reg_control = 2'd2,
		reg_none    = 2'd3
	} kbd_reg_e;

endpackage

`default_nettype wire

//--- flist.f
+incdir+common
common/kbd_pkg.sv
verilog/kbd_fifo.sv
ps2_keyboard/ps2_frame_rx.sv
ps2_keyboard/kbd_reg_exec.sv
ps2_keyboard/kbd_irq_ctrl.sv
verilog/kbd_device.sv
bench/kbd_device_tb.sv

//--- ps2_keyboard/kbd_irq_ctrl.sv
// One request per burst of codes; irq_data is the occupancy right after the triggering push
`timescale 1ns/1ns
`default_nettype none
`include "kbd_consts.svh"

module kbd_irq_ctrl
	import kbd_pkg::*;
(
	input  wire                                  clock,
	input  wire                                  rst_n,
	input  wire                                  irq_enable,
	input  wire                                  scan_push,
	input  wire [$clog2(`KBD_SCAN_DEPTH+1)-1:0]  scan_count,
	input  wire                                  irq_busy,
	input  wire                                  irq_ack,
	output logic                                 irq_req,
	output irq_data_t                            irq_data
);

	localparam int SCNT_W = $clog2(`KBD_SCAN_DEPTH + 1);

	// Push seen while the host was busy
	logic armed;
	logic raise;
	logic [SCNT_W-1:0] occupancy;

	// Count as it will be once the push lands
	assign occupancy = scan_push ? scan_count + 1'b1 : scan_count;
	assign raise = (scan_push | armed) & irq_enable & ~irq_req & ~irq_busy;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			irq_req <= 1'b0;
			irq_data <= '0;
			armed <= 1'b0;
		end else begin
			// Level held until the host acks
			if (irq_ack) begin
				irq_req <= 1'b0;
			end else if (raise) begin
				irq_req <= 1'b1;
				irq_data <= irq_data_t'(occupancy);
			end
			if (raise | ~irq_enable) begin
				armed <= 1'b0;
			end else if (scan_push & ~irq_req & irq_busy) begin
				armed <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- ps2_keyboard/kbd_reg_exec.sv
// Exact address match only; one read at a time travels into the reply queue, so busy pulses per read
`timescale 1ns/1ns
`default_nettype none
`include "kbd_consts.svh"

module kbd_reg_exec
	import kbd_pkg::*;
(
	input  wire                                    clock,
	input  wire                                    rst_n,
	input  wire                                    dev_req,
	input  wire                                    dev_rw,
	input  wire gci_addr_t                         dev_addr,
	input  wire gci_data_t                         dev_data_in,
	input  wire                                    reply_full,
	input  wire scan_code_t                        scan_code,
	input  wire                                    scan_empty,
	input  wire [$clog2(`KBD_SCAN_DEPTH+1)-1:0]    scan_count,
	input  wire                                    code_valid,
	input  wire                                    frame_error,
	output logic                                   dev_busy,
	output logic                                   scan_pop,
	output logic                                   reply_push,
	output gci_data_t                              reply_data,
	output logic                                   irq_enable
);

	localparam int SCNT_W = $clog2(`KBD_SCAN_DEPTH + 1);

	kbd_reg_e sel;
	logic accept;
	logic rd_accept;
	logic wr_ctrl;
	logic scan_full;
	logic overflow_q;
	logic frame_err_q;
	gci_data_t status_word;
	gci_data_t read_word;

	// Hold off while the queue is full or a reply is still on its way in
	assign dev_busy = reply_full | reply_push;
	assign accept = dev_req & ~dev_busy;
	assign rd_accept = accept & ~dev_rw;
	assign wr_ctrl = accept & dev_rw & (sel == reg_control);

	// Address decode
	always_comb begin
		case (dev_addr)
			`KBD_ADDR_STATUS: sel = reg_status;
			`KBD_ADDR_DATA: sel = reg_data;
			`KBD_ADDR_CONTROL: sel = reg_control;
			default: sel = reg_none;
		endcase
	end

	// Data read takes the head, empty queue gives zero
	assign scan_pop = rd_accept & (sel == reg_data) & ~scan_empty;
	assign scan_full = (scan_count == SCNT_W'(`KBD_SCAN_DEPTH));

	always_comb begin
		status_word = '0;
		status_word[0] = ~scan_empty;
		status_word[1] = overflow_q;
		status_word[2] = frame_err_q;
		status_word[3] = irq_enable;
		status_word[8 +: SCNT_W] = scan_count;
	end

	always_comb begin
		case (sel)
			reg_status: read_word = status_word;
			reg_data: read_word = scan_empty ? '0 : gci_data_t'(scan_code);
			reg_control: read_word = gci_data_t'(irq_enable);
			default: read_word = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			reply_push <= 1'b0;
			irq_enable <= 1'b0;
			overflow_q <= 1'b0;
			frame_err_q <= 1'b0;
		end else begin
			reply_push <= rd_accept;
			if (wr_ctrl) begin
				irq_enable <= dev_data_in[0];
				if (dev_data_in[1]) begin
					overflow_q <= 1'b0;
					frame_err_q <= 1'b0;
				end
			end
			// New events win over a clear in the same cycle
			if (code_valid & scan_full) begin
				overflow_q <= 1'b1;
			end
			if (frame_error) begin
				frame_err_q <= 1'b1;
			end
		end
	end

	// Reply word, goes into the queue next cycle
	always_ff @(posedge clock) begin
		if (rd_accept) begin
			reply_data <= read_word;
		end
	end

endmodule

`default_nettype wire

//--- ps2_keyboard/ps2_frame_rx.sv
// Receive only; PS/2 clock must be much slower than clock, pins may be fully asynchronous
`timescale 1ns/1ns
`default_nettype none
`include "kbd_consts.svh"

module ps2_frame_rx
	import kbd_pkg::*;
(
	input  wire        clock,
	input  wire        rst_n,
	input  wire        ps2_clock,
	input  wire        ps2_data,
	output logic       code_valid,
	output scan_code_t code,
	output logic       frame_error
);

	localparam int TMO_W = $clog2(`KBD_PS2_TIMEOUT + 1);

	// Two flop synchronizers, idle level is high
	logic [1:0] clk_sync;
	logic [1:0] dat_sync;
	logic clk_prev;
	logic fall;

	// Frame assembly
	logic [10:0] shift_q;
	logic [3:0] bit_cnt;
	logic [TMO_W-1:0] idle_cnt;
	logic [10:0] frame;
	logic frame_ok;
	logic last_bit;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clock};
			dat_sync <= {dat_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
		end
	end

	// One cycle strobe per falling keyboard clock
	assign fall = clk_prev & ~clk_sync[1];

	// Stop bit is still on the pin, the other ten are shifted in
	// frame[0] start, [8:1] data LSB first, [9] parity, [10] stop
	assign frame = {dat_sync[1], shift_q[10:1]};
	assign last_bit = fall && (bit_cnt == 4'd10);

	// Start low, stop high, odd parity over data and parity bit
	assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			idle_cnt <= '0;
			code_valid <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			frame_error <= 1'b0;
			if (fall) begin
				idle_cnt <= '0;
				if (last_bit) begin
					bit_cnt <= '0;
					code_valid <= frame_ok;
					frame_error <= ~frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != 4'd0) begin
				// Keyboard went quiet mid frame
				if (idle_cnt == TMO_W'(`KBD_PS2_TIMEOUT)) begin
					bit_cnt <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	// Payload shifter, LSB arrives first
	always_ff @(posedge clock) begin
		if (fall) begin
			shift_q <= {dat_sync[1], shift_q[10:1]};
		end
	end

	// After the last shift the data byte sits in 8:1
	assign code = shift_q[8:1];

endmodule

`default_nettype wire

//--- verilog/kbd_device.sv
// No PS/2 transmit and no scan-code translation; codes are raw set-2 bytes from the keyboard
`timescale 1ns/1ns
`default_nettype none
`include "kbd_consts.svh"

module kbd_device
	import kbd_pkg::*;
(
	input  wire             clock,
	input  wire             rst_n,
	input  wire             dev_req,
	input  wire             dev_rw,
	input  wire gci_addr_t  dev_addr,
	input  wire gci_data_t  dev_data_in,
	output logic            dev_busy,
	output logic            rsp_req,
	output gci_data_t       rsp_data,
	input  wire             rsp_busy,
	output logic            irq_req,
	output irq_data_t       irq_data,
	input  wire             irq_busy,
	input  wire             irq_ack,
	input  wire             ps2_clock,
	input  wire             ps2_data
);

	// Receiver side
	logic code_valid;
	scan_code_t code;
	logic frame_error;

	// Scan queue
	logic scan_push;
	logic scan_pop;
	scan_code_t scan_head;
	logic scan_empty;
	logic scan_full;
	logic [$clog2(`KBD_SCAN_DEPTH+1)-1:0] scan_count;

	// Reply queue
	logic reply_push;
	gci_data_t reply_data;
	logic reply_empty;
	logic reply_full;

	logic irq_enable;

	// Codes arriving on a full queue are dropped, the register block flags them
	assign scan_push = code_valid & ~scan_full;

	// Head reply leaves whenever the host can take it
	assign rsp_req = ~reply_empty & ~rsp_busy;

	ps2_frame_rx frame_rx_i (
		.clock(clock),
		.rst_n(rst_n),
		.ps2_clock(ps2_clock),
		.ps2_data(ps2_data),
		.code_valid(code_valid),
		.code(code),
		.frame_error(frame_error)
	);

	kbd_fifo #(
		.payload_t(scan_code_t),
		.DEPTH(`KBD_SCAN_DEPTH)
	) scan_fifo_i (
		.clock(clock),
		.rst_n(rst_n),
		.push(scan_push),
		.push_data(code),
		.pop(scan_pop),
		.pop_data(scan_head),
		.empty(scan_empty),
		.full(scan_full),
		.count(scan_count)
	);

	kbd_reg_exec reg_exec_i (
		.clock(clock),
		.rst_n(rst_n),
		.dev_req(dev_req),
		.dev_rw(dev_rw),
		.dev_addr(dev_addr),
		.dev_data_in(dev_data_in),
		.reply_full(reply_full),
		.scan_code(scan_head),
		.scan_empty(scan_empty),
		.scan_count(scan_count),
		.code_valid(code_valid),
		.frame_error(frame_error),
		.dev_busy(dev_busy),
		.scan_pop(scan_pop),
		.reply_push(reply_push),
		.reply_data(reply_data),
		.irq_enable(irq_enable)
	);

	// Replies keep request order
	kbd_fifo #(
		.payload_t(gci_data_t),
		.DEPTH(`KBD_REPLY_DEPTH)
	) reply_fifo_i (
		.clock(clock),
		.rst_n(rst_n),
		.push(reply_push),
		.push_data(reply_data),
		.pop(rsp_req),
		.pop_data(rsp_data),
		.empty(reply_empty),
		.full(reply_full),
		.count()
	);

	kbd_irq_ctrl irq_ctrl_i (
		.clock(clock),
		.rst_n(rst_n),
		.irq_enable(irq_enable),
		.scan_push(scan_push),
		.scan_count(scan_count),
		.irq_busy(irq_busy),
		.irq_ack(irq_ack),
		.irq_req(irq_req),
		.irq_data(irq_data)
	);

endmodule

`default_nettype wire

//--- verilog/kbd_fifo.sv
// Push when full and pop when empty are ignored; pop_data is the head entry, valid when not empty
`timescale 1ns/1ns
`default_nettype none

module kbd_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input  wire                          clock,
	input  wire                          rst_n,
	input  wire                          push,
	input  wire payload_t                push_data,
	input  wire                          pop,
	output payload_t                     pop_data,
	output logic                         empty,
	output logic                         full,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap at DEPTH, not only at a power of two
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	assign pop_data = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire
